/* tomasulo_settings.svh */
`ifndef TOMASULO_SETTINGS_SVH
`define TOMASULO_SETTINGS_SVH

`define XLEN 32
// Register index is 3 bits
`define NUM_REGS 8
`define RS_ENTRIES 2
// Tag 0 marks a ready value with no producer
`define TAG_W 3
`define ALU_TAG_BASE 1
`define MUL_TAG_BASE 3
`define MUL_LATENCY 4

`endif

/* tomasulo_pkg.sv */
`include "tomasulo_settings.svh"

package tomasulo_pkg;

  typedef logic [`TAG_W-1:0] tag_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;
  typedef logic [$clog2(`RS_ENTRIES)-1:0] rs_idx_t;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_li,
    op_mul
  } opcode_t;

  typedef struct packed {
    opcode_t op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic [`XLEN-1:0] imm;
  } instr_t;

  typedef struct packed {
    tag_t tag;
    logic [`XLEN-1:0] value;
  } operand_t;

  typedef struct packed {
    opcode_t op;
    tag_t tag;
    operand_t src1;
    operand_t src2;
  } issue_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
    logic [`XLEN-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic req;
    tag_t tag;
    logic [`XLEN-1:0] value;
  } cdb_req_t;

  typedef struct packed {
    logic valid;
    logic started;
    opcode_t op;
    operand_t src1;
    operand_t src2;
  } rs_entry_t;

  typedef rs_entry_t station_t [`RS_ENTRIES];

  typedef struct packed {
    logic found;
    rs_idx_t idx;
  } rs_pick_t;

  // Capture a broadcast result into a waiting operand
  function automatic operand_t snoop(operand_t src, cdb_t bus);
    if (bus.valid && src.tag != '0 && src.tag == bus.tag) begin
      return operand_t'{tag: '0, value: bus.value};
    end
    return src;
  endfunction

  function automatic logic is_ready(rs_entry_t e);
    return e.valid && !e.started && e.src1.tag == '0 && e.src2.tag == '0;
  endfunction

  function automatic logic station_full(station_t st);
    logic full;
    full = 1'b1;
    for (int i = 0; i < `RS_ENTRIES; i++) begin
      full &= st[i].valid;
    end
    return full;
  endfunction

  // Lowest free entry of a station that still has room
  function automatic rs_idx_t first_free(station_t st);
    rs_idx_t idx;
    idx = '0;
    for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
      if (!st[i].valid) idx = rs_idx_t'(i);
    end
    return idx;
  endfunction

  function automatic rs_pick_t oldest_ready(station_t st, rs_idx_t oldest);
    rs_pick_t pick;
    rs_idx_t idx;
    pick = '0;
    for (int k = `RS_ENTRIES - 1; k >= 0; k--) begin
      idx = oldest + rs_idx_t'(k);
      if (is_ready(st[idx])) pick = '{found: 1'b1, idx: idx};
    end
    return pick;
  endfunction

  // Age pointer for a two-entry station
  function automatic rs_idx_t next_oldest(station_t st, rs_idx_t oldest, logic alloc,
                                          rs_idx_t alloc_idx, logic free_en,
                                          rs_idx_t free_idx);
    rs_idx_t other;
    other = alloc_idx + 1'b1;
    if (alloc && !(st[other].valid && !(free_en && free_idx == other))) return alloc_idx;
    if (free_en && free_idx == oldest) return oldest + 1'b1;
    return oldest;
  endfunction

endpackage

/* register_file.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module register_file (
  input  logic clock,
  input  logic reset,
  input  tomasulo_pkg::reg_idx_t query_rs1,
  input  tomasulo_pkg::reg_idx_t query_rs2,
  output tomasulo_pkg::operand_t operand1,
  output tomasulo_pkg::operand_t operand2,
  input  logic rename_valid,
  input  tomasulo_pkg::reg_idx_t rename_rd,
  input  tomasulo_pkg::tag_t rename_tag,
  input  tomasulo_pkg::cdb_t cdb,
  input  tomasulo_pkg::reg_idx_t dbg_addr,
  output logic [`XLEN-1:0] dbg_data,
  output logic dbg_pending
);
  import tomasulo_pkg::*;

  logic [`XLEN-1:0] regs [`NUM_REGS];
  tag_t tags [`NUM_REGS];  // Producer of the pending value

  // A result on the bus this cycle is handed straight to the reader
  assign operand1 = snoop(operand_t'{tag: tags[query_rs1], value: regs[query_rs1]}, cdb);
  assign operand2 = snoop(operand_t'{tag: tags[query_rs2], value: regs[query_rs2]}, cdb);

  assign dbg_data = regs[dbg_addr];
  assign dbg_pending = tags[dbg_addr] != '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        if (cdb.valid && tags[i] == cdb.tag) begin  // Only the latest producer writes
          regs[i] <= cdb.value;
          tags[i] <= '0;
        end
      end
      if (rename_valid) tags[rename_rd] <= rename_tag;  // Overrides a same-edge write
    end
  end

endmodule

/* instr_issue.sv */
`timescale 1ns/1ps

module instr_issue (
  input  tomasulo_pkg::instr_t instr,
  input  logic instr_valid,
  output logic stall,
  output tomasulo_pkg::reg_idx_t query_rs1,
  output tomasulo_pkg::reg_idx_t query_rs2,
  input  tomasulo_pkg::operand_t operand1,
  input  tomasulo_pkg::operand_t operand2,
  output logic rename_valid,
  output tomasulo_pkg::reg_idx_t rename_rd,
  output tomasulo_pkg::tag_t rename_tag,
  input  logic alu_full,
  input  logic mul_full,
  input  tomasulo_pkg::tag_t alu_free_tag,
  input  tomasulo_pkg::tag_t mul_free_tag,
  output tomasulo_pkg::issue_t issue,
  output logic alu_issue_valid,
  output logic mul_issue_valid
);
  import tomasulo_pkg::*;

  logic to_mul;
  logic accept;

  assign to_mul = instr.op == op_mul;
  assign stall = instr_valid && (to_mul ? mul_full : alu_full);
  assign accept = instr_valid && !stall;

  assign query_rs1 = instr.rs1;
  assign query_rs2 = instr.rs2;

  assign rename_valid = accept;
  assign rename_rd = instr.rd;
  assign rename_tag = to_mul ? mul_free_tag : alu_free_tag;

  assign alu_issue_valid = accept && !to_mul;
  assign mul_issue_valid = accept && to_mul;

  always_comb begin
    issue.op = instr.op;
    issue.tag = rename_tag;
    issue.src1 = operand1;
    issue.src2 = operand2;
    if (instr.op == op_li) begin
      issue.src1 = operand_t'{tag: '0, value: '0};  // Never waits on rs1
      issue.src2 = operand_t'{tag: '0, value: instr.imm};
    end
  end

endmodule

/* alu_combo.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module alu_combo (
  input  logic clock,
  input  logic reset,
  input  tomasulo_pkg::issue_t issue,
  input  logic issue_valid,
  input  tomasulo_pkg::cdb_t cdb,
  output logic full,
  output tomasulo_pkg::tag_t free_tag,
  output tomasulo_pkg::cdb_req_t cdb_req,
  input  logic grant
);
  import tomasulo_pkg::*;

  station_t station;
  rs_idx_t oldest;
  rs_idx_t wr_idx;
  rs_idx_t done_idx;
  rs_pick_t pick;
  logic start;
  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [`XLEN-1:0] result;

  assign full = station_full(station);
  assign free_tag = tag_t'(`ALU_TAG_BASE + first_free(station));
  assign wr_idx = rs_idx_t'(issue.tag - `ALU_TAG_BASE);
  assign done_idx = rs_idx_t'(cdb_req.tag - `ALU_TAG_BASE);  // Entry behind the held result
  assign pick = oldest_ready(station, oldest);
  assign start = pick.found && (!cdb_req.req || grant);

  assign a = station[pick.idx].src1.value;
  assign b = station[pick.idx].src2.value;

  always_comb begin
    case (station[pick.idx].op)
      op_add: result = a + b;
      op_sub: result = a - b;
      op_and: result = a & b;
      op_xor: result = a ^ b;
      default: result = b;  // op_li takes the immediate in src2
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RS_ENTRIES; i++) begin
        station[i].valid <= 1'b0;
        station[i].started <= 1'b0;
      end
      cdb_req.req <= 1'b0;
      oldest <= '0;
    end else begin
      for (int i = 0; i < `RS_ENTRIES; i++) begin
        station[i].src1 <= snoop(station[i].src1, cdb);
        station[i].src2 <= snoop(station[i].src2, cdb);
      end
      if (grant) station[done_idx].valid <= 1'b0;
      if (start) begin
        station[pick.idx].started <= 1'b1;
        cdb_req <= '{req: 1'b1, tag: tag_t'(`ALU_TAG_BASE + pick.idx), value: result};
      end else if (grant) begin
        cdb_req.req <= 1'b0;
      end
      if (issue_valid) begin
        station[wr_idx] <= '{valid: 1'b1, started: 1'b0, op: issue.op,
                             src1: issue.src1, src2: issue.src2};
      end
      oldest <= next_oldest(station, oldest, issue_valid, wr_idx, grant, done_idx);
    end
  end

endmodule

/* mult_combo.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module mult_combo (
  input  logic clock,
  input  logic reset,
  input  tomasulo_pkg::issue_t issue,
  input  logic issue_valid,
  input  tomasulo_pkg::cdb_t cdb,
  output logic full,
  output tomasulo_pkg::tag_t free_tag,
  output tomasulo_pkg::cdb_req_t cdb_req,
  input  logic grant
);
  import tomasulo_pkg::*;

  localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

  typedef enum logic [1:0] {
    mul_idle,
    mul_busy,
    mul_done
  } mul_state_t;

  mul_state_t state;
  station_t station;
  rs_idx_t oldest;
  rs_idx_t wr_idx;
  rs_idx_t cur_idx;  // Entry being multiplied
  rs_pick_t pick;
  logic start;
  logic [CNT_W-1:0] count;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] product;

  assign full = station_full(station);
  assign free_tag = tag_t'(`MUL_TAG_BASE + first_free(station));
  assign wr_idx = rs_idx_t'(issue.tag - `MUL_TAG_BASE);
  assign pick = oldest_ready(station, oldest);
  assign start = pick.found && state == mul_idle;

  assign cdb_req = '{req: state == mul_done,
                     tag: tag_t'(`MUL_TAG_BASE + cur_idx),
                     value: product};

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RS_ENTRIES; i++) begin
        station[i].valid <= 1'b0;
        station[i].started <= 1'b0;
      end
      state <= mul_idle;
      oldest <= '0;
    end else begin
      for (int i = 0; i < `RS_ENTRIES; i++) begin
        station[i].src1 <= snoop(station[i].src1, cdb);
        station[i].src2 <= snoop(station[i].src2, cdb);
      end
      case (state)
        mul_idle: begin
          if (start) begin
            station[pick.idx].started <= 1'b1;
            cur_idx <= pick.idx;
            op_a <= station[pick.idx].src1.value;
            op_b <= station[pick.idx].src2.value;
            count <= CNT_W'(`MUL_LATENCY - 1);
            state <= mul_busy;
          end
        end
        mul_busy: begin
          if (count == CNT_W'(1)) begin
            product <= op_a * op_b;  // Low word only
            state <= mul_done;
          end else begin
            count <= count - 1'b1;
          end
        end
        default: begin
          if (grant) begin
            station[cur_idx].valid <= 1'b0;
            state <= mul_idle;
          end
        end
      endcase
      if (issue_valid) begin
        station[wr_idx] <= '{valid: 1'b1, started: 1'b0, op: issue.op,
                             src1: issue.src1, src2: issue.src2};
      end
      oldest <= next_oldest(station, oldest, issue_valid, wr_idx, grant, cur_idx);
    end
  end

endmodule

/* cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic clock,
  input  logic reset,
  input  tomasulo_pkg::cdb_req_t alu_req,
  input  tomasulo_pkg::cdb_req_t mul_req,
  output logic alu_grant,
  output logic mul_grant,
  output tomasulo_pkg::cdb_t cdb
);

  logic last_mul;  // Multiplier took the previous grant

  assign alu_grant = alu_req.req && (!mul_req.req || last_mul);
  assign mul_grant = mul_req.req && !alu_grant;

  always_comb begin
    cdb = '0;
    if (alu_grant) cdb = '{valid: 1'b1, tag: alu_req.tag, value: alu_req.value};
    else if (mul_grant) cdb = '{valid: 1'b1, tag: mul_req.tag, value: mul_req.value};
  end

  always_ff @(posedge clock) begin
    if (reset) last_mul <= 1'b0;
    else if (alu_grant || mul_grant) last_mul <= mul_grant;
  end

endmodule

/* tomasulo_core.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module tomasulo_core (
  input  logic clock,
  input  logic reset,
  input  tomasulo_pkg::instr_t instr,
  input  logic instr_valid,
  output logic stall,
  output tomasulo_pkg::cdb_t cdb,
  input  logic [$clog2(`NUM_REGS)-1:0] dbg_addr,
  output logic [`XLEN-1:0] dbg_data,
  output logic dbg_pending
);
  import tomasulo_pkg::*;

  reg_idx_t query_rs1;
  reg_idx_t query_rs2;
  operand_t operand1;
  operand_t operand2;
  logic rename_valid;
  reg_idx_t rename_rd;
  tag_t rename_tag;
  logic alu_full;
  logic mul_full;
  tag_t alu_free_tag;
  tag_t mul_free_tag;
  issue_t issue;  // Shared by both stations
  logic alu_issue_valid;
  logic mul_issue_valid;
  cdb_req_t alu_req;
  cdb_req_t mul_req;
  logic alu_grant;
  logic mul_grant;

  register_file reg_file (
    .clock(clock),
    .reset(reset),
    .query_rs1(query_rs1),
    .query_rs2(query_rs2),
    .operand1(operand1),
    .operand2(operand2),
    .rename_valid(rename_valid),
    .rename_rd(rename_rd),
    .rename_tag(rename_tag),
    .cdb(cdb),
    .dbg_addr(dbg_addr),
    .dbg_data(dbg_data),
    .dbg_pending(dbg_pending)
  );

  instr_issue instr_issue (
    .instr(instr),
    .instr_valid(instr_valid),
    .stall(stall),
    .query_rs1(query_rs1),
    .query_rs2(query_rs2),
    .operand1(operand1),
    .operand2(operand2),
    .rename_valid(rename_valid),
    .rename_rd(rename_rd),
    .rename_tag(rename_tag),
    .alu_full(alu_full),
    .mul_full(mul_full),
    .alu_free_tag(alu_free_tag),
    .mul_free_tag(mul_free_tag),
    .issue(issue),
    .alu_issue_valid(alu_issue_valid),
    .mul_issue_valid(mul_issue_valid)
  );

  alu_combo alu_combo (
    .clock(clock),
    .reset(reset),
    .issue(issue),
    .issue_valid(alu_issue_valid),
    .cdb(cdb),
    .full(alu_full),
    .free_tag(alu_free_tag),
    .cdb_req(alu_req),
    .grant(alu_grant)
  );

  mult_combo mult_combo (
    .clock(clock),
    .reset(reset),
    .issue(issue),
    .issue_valid(mul_issue_valid),
    .cdb(cdb),
    .full(mul_full),
    .free_tag(mul_free_tag),
    .cdb_req(mul_req),
    .grant(mul_grant)
  );

  cdb_arbiter cdb_arbiter (
    .clock(clock),
    .reset(reset),
    .alu_req(alu_req),
    .mul_req(mul_req),
    .alu_grant(alu_grant),
    .mul_grant(mul_grant),
    .cdb(cdb)
  );

endmodule

/* tomasulo_checker.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module tomasulo_checker (
  input logic clock,
  input logic reset,
  input logic instr_valid,
  input logic stall,
  input logic mul_issue_valid,
  input tomasulo_pkg::issue_t issue,
  input tomasulo_pkg::cdb_t cdb
);
  import tomasulo_pkg::*;

  int failures = 0;
  logic [7:0] mul_age [`RS_ENTRIES];  // Cycles since each multiplier tag was issued
  logic mul_early;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RS_ENTRIES; i++) mul_age[i] <= '1;
    end else begin
      for (int i = 0; i < `RS_ENTRIES; i++) begin
        if (mul_issue_valid && issue.tag == tag_t'(`MUL_TAG_BASE + i)) mul_age[i] <= '0;
        else if (mul_age[i] != '1) mul_age[i] <= mul_age[i] + 1'b1;  // Saturates
      end
    end
  end

  always_comb begin
    mul_early = 1'b0;
    for (int i = 0; i < `RS_ENTRIES; i++) begin
      if (cdb.valid && cdb.tag == tag_t'(`MUL_TAG_BASE + i) &&
          mul_age[i] < 8'(`MUL_LATENCY)) mul_early = 1'b1;
    end
  end

  tag_nonzero: assert property (@(posedge clock) disable iff (reset)
      cdb.valid |-> cdb.tag != '0)
    else begin
      $error("CDB broadcast carries tag 0");
      failures++;
    end

  tag_in_range: assert property (@(posedge clock) disable iff (reset)
      cdb.valid |-> (cdb.tag >= tag_t'(`ALU_TAG_BASE) &&
                     cdb.tag <= tag_t'(`MUL_TAG_BASE + `RS_ENTRIES - 1)))
    else begin
      $error("CDB broadcast carries an unknown tag %0d", cdb.tag);
      failures++;
    end

  stall_needs_valid: assert property (@(posedge clock) stall |-> instr_valid)
    else begin
      $error("stall high without instr_valid");
      failures++;
    end

  stall_quiet_in_reset: assert property (@(posedge clock) reset |-> !stall)
    else begin
      $error("stall high during reset");
      failures++;
    end

  stall_quiet_after_reset: assert property (@(posedge clock) $fell(reset) |-> !stall)
    else begin
      $error("stall high right after reset");
      failures++;
    end

  mul_not_early: assert property (@(posedge clock) disable iff (reset) !mul_early)
    else begin
      $error("Multiplier result broadcast before its latency elapsed");
      failures++;
    end

endmodule

bind tomasulo_core tomasulo_checker core_checks (
  .clock(clock),
  .reset(reset),
  .instr_valid(instr_valid),
  .stall(stall),
  .mul_issue_valid(mul_issue_valid),
  .issue(issue),
  .cdb(cdb)
);

/* tb_tomasulo_core.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module tb_tomasulo_core;
  import tomasulo_pkg::*;

  localparam int PROG_LEN = 60;
  localparam int STALL_LIMIT = 200;
  localparam int DRAIN_LIMIT = 500;

  logic clock;
  logic reset;
  instr_t instr;
  logic instr_valid;
  logic stall;
  cdb_t cdb;
  reg_idx_t dbg_addr;
  logic [`XLEN-1:0] dbg_data;
  logic dbg_pending;

  integer seed = 32'h7dc26ccb;
  int errors = 0;
  int timeouts = 0;
  instr_t prog [$];
  logic [`XLEN-1:0] model [`NUM_REGS];  // In-order register state

  tomasulo_core dut (
    .clock(clock),
    .reset(reset),
    .instr(instr),
    .instr_valid(instr_valid),
    .stall(stall),
    .cdb(cdb),
    .dbg_addr(dbg_addr),
    .dbg_data(dbg_data),
    .dbg_pending(dbg_pending)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic build_program();
    instr_t ins;
    for (int i = 0; i < PROG_LEN; i++) begin
      ins.op = opcode_t'(3'($unsigned($random(seed)) % 6));
      ins.rd = reg_idx_t'($random(seed));
      ins.rs1 = reg_idx_t'($random(seed));
      ins.rs2 = reg_idx_t'($random(seed));
      ins.imm = $random(seed);
      if (i < `NUM_REGS) begin
        ins.op = op_li;  // Seed every register first
        ins.rd = reg_idx_t'(i);
      end else if (i % 20 >= 8 && i % 20 < 12) begin
        // Each multiply reads the result of the one before it
        ins.op = op_mul;
        ins.rd = reg_idx_t'(i / 20 + 1);
        ins.rs1 = ins.rd;
      end
      prog.push_back(ins);
    end
  endtask

  function automatic void apply_model(instr_t ins);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    a = model[ins.rs1];
    b = model[ins.rs2];
    case (ins.op)
      op_add: model[ins.rd] = a + b;
      op_sub: model[ins.rd] = a - b;
      op_and: model[ins.rd] = a & b;
      op_xor: model[ins.rd] = a ^ b;
      op_mul: model[ins.rd] = a * b;  // Low word
      default: model[ins.rd] = ins.imm;
    endcase
  endfunction

  // Starts and ends on a falling edge
  task automatic send(input instr_t ins, output logic taken);
    int waits;
    instr = ins;
    instr_valid = 1'b1;
    taken = 1'b0;
    waits = 0;
    while (!taken && waits < STALL_LIMIT) begin
      #5;
      taken = !stall;
      @(negedge clock);
      waits++;
    end
    if (!taken) begin
      $display("Timeout at %0t: instruction was never accepted, stall stayed high", $time);
      timeouts++;
    end
    instr_valid = 1'b0;
  endtask

  task automatic check_registers();
    for (int r = 0; r < `NUM_REGS; r++) begin
      dbg_addr = reg_idx_t'(r);
      #1;
      assert (dbg_data == model[r]) else begin
        $display("** Error at %0t: r%0d is %h, expected %h", $time, r, dbg_data, model[r]);
        errors++;
      end
      assert (!dbg_pending) else begin
        $display("** Error at %0t: r%0d still pending after drain", $time, r);
        errors++;
      end
    end
  endtask

  initial begin
    logic taken;
    logic busy;
    int cycles;
    instr = '0;
    instr_valid = 1'b0;
    reset = 1'b1;
    dbg_addr = '0;
    for (int r = 0; r < `NUM_REGS; r++) model[r] = '0;
    build_program();
    repeat (2) @(negedge clock);
    instr = prog[0];
    instr_valid = 1'b1;  // Offered while the core is still held in reset
    repeat (8) @(negedge clock);
    reset = 1'b0;
    foreach (prog[i]) begin
      if (i > 0 && ($random(seed) & 7) == 0) @(negedge clock);  // Idle bubble
      send(prog[i], taken);
      if (taken) apply_model(prog[i]);
    end
    busy = 1'b1;
    cycles = 0;
    while (busy && cycles < DRAIN_LIMIT) begin
      @(negedge clock);
      busy = 1'b0;
      for (int r = 0; r < `NUM_REGS; r++) begin
        dbg_addr = reg_idx_t'(r);
        #1;
        busy |= dbg_pending;
      end
      cycles++;
    end
    if (busy) begin
      $display("Timeout at %0t: registers still pending after the drain", $time);
      timeouts++;
    end
    @(negedge clock);
    check_registers();
    $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, dut.core_checks.failures);
    if (errors == 0 && timeouts == 0 && dut.core_checks.failures == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* tomasulo_core.f */
+incdir+.
tomasulo_pkg.sv
register_file.sv
instr_issue.sv
alu_combo.sv
mult_combo.sv
cdb_arbiter.sv
tomasulo_core.sv
tomasulo_checker.sv
tb_tomasulo_core.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the simulation output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f tomasulo_core.f \
    --top-module tb_tomasulo_core -o sim_tomasulo_core &&
  ./obj_dir/sim_tomasulo_core +verilator+error+limit+100 | tee /dev/stderr |
    grep -q -x -F '** PASS **' &&
  echo "run_sim: simulation passed" || { echo "run_sim: simulation failed"; exit 1; }
